// ==== source/zmem_params.svh ====
`ifndef ZMEM_PARAMS_SVH
`define ZMEM_PARAMS_SVH

// page number width inside one half of memory
`define ZMEM_PAGE_BITS 4

// offset width inside a 16 KB window
`define ZMEM_WIN_BITS 14

// request queue entries and starting credits
`define ZMEM_QUEUE_DEPTH 4

// fclk cycles per memory cycle
`define ZMEM_CYCLE_LEN 4

// low address bytes of the pager ports
`define ZMEM_PORT_PAGE 8'hF7
`define ZMEM_PORT_CFG 8'h77

`endif

// ==== source/zmem_pkg.sv ====
`include "zmem_params.svh"

package zmem_pkg;

	// z80 side
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] mem_data_t;

	// window page number
	typedef logic [`ZMEM_PAGE_BITS-1:0] page_t;

	// rom flag on top, then page, then window offset
	typedef logic [`ZMEM_PAGE_BITS+`ZMEM_WIN_BITS:0] phys_addr_t;

	typedef enum logic
	{
		OP_READ,
		OP_WRITE
	} mem_op_e;

	typedef enum logic [1:0]
	{
		SEQ_IDLE,
		SEQ_CBEG,
		SEQ_ACCESS,
		SEQ_CEND
	} seq_state_e;

endpackage

// ==== source/zpager.sv ====
`include "zmem_params.svh"

module zpager
(
	input  logic                  fclk,
	input  logic                  reset,

	// cpu request port
	input  logic                  req,
	input  zmem_pkg::mem_op_e     req_op,
	input  zmem_pkg::cpu_addr_t   req_addr,
	input  zmem_pkg::mem_data_t   req_wrdata,

	// port writes
	input  logic                  port_wr,
	input  zmem_pkg::cpu_addr_t   port_addr,
	input  zmem_pkg::mem_data_t   port_data,

	// one credit back per pop in the sequencer
	input  logic                  credit_ret,

	output logic                  busy,

	// towards the request queue
	output logic                  push,
	output zmem_pkg::mem_op_e     push_op,
	output zmem_pkg::phys_addr_t  push_addr,
	output zmem_pkg::mem_data_t   push_data
);
	import zmem_pkg::*;

	localparam int credit_bits = $clog2(`ZMEM_QUEUE_DEPTH + 1);
	localparam logic [credit_bits-1:0] credit_init = credit_bits'(`ZMEM_QUEUE_DEPTH);

	// window mapping state
	page_t      win_page [0:3];
	logic [3:0] win_rom;
	logic       romrw_en;

	logic [credit_bits-1:0] credits;

	logic       page_hit;
	logic       cfg_hit;
	logic [1:0] port_win;

	logic [1:0] req_win;
	logic       accept;
	logic       rom_drop;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	assign page_hit = port_wr && (port_addr[7:0] == `ZMEM_PORT_PAGE);
	assign cfg_hit  = port_wr && (port_addr[7:0] == `ZMEM_PORT_CFG);

	// high address bits pick the window for the page port
	assign port_win = port_addr[15:14];

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			// rom page 0 in window 0, ram pages 1..3 above it
			win_rom <= 4'b0001;
			for (int i = 0; i < 4; i++)
			begin
				win_page[i] <= page_t'(i);
			end
		end
		else if (page_hit)
		begin
			// data bit 7 set means ram
			win_rom[port_win]  <= ~port_data[7];
			win_page[port_win] <= port_data[`ZMEM_PAGE_BITS-1:0];
		end
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			romrw_en <= 1'b0;
		end
		else if (cfg_hit)
		begin
			romrw_en <= port_data[0];
		end
	end

	////////////////////////////////////////////////////////////
	// address translation
	////////////////////////////////////////////////////////////

	assign req_win = req_addr[15:14];

	assign accept = req && !busy;

	// rom write while protected is swallowed here
	assign rom_drop = (req_op == OP_WRITE) && win_rom[req_win] && !romrw_en;

	assign push      = accept && !rom_drop;
	assign push_op   = req_op;
	assign push_data = req_wrdata;
	assign push_addr = {win_rom[req_win], win_page[req_win], req_addr[`ZMEM_WIN_BITS-1:0]};

	////////////////////////////////////////////////////////////
	// credits
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			credits <= credit_init;
		end
		else
		begin
			case ({push, credit_ret})
				2'b10:
				begin
					credits <= credits - 1'b1;
				end
				2'b01:
				begin
					credits <= credits + 1'b1;
				end
				default:
				begin
					credits <= credits;
				end
			endcase
		end
	end

	// no credit left means the queue could be full
	assign busy = (credits == '0);

endmodule

// ==== source/req_queue.sv ====
module req_queue
#(
	parameter int depth = 4
)
(
	input  logic                  fclk,
	input  logic                  reset,

	input  logic                  push,
	input  zmem_pkg::mem_op_e     push_op,
	input  zmem_pkg::phys_addr_t  push_addr,
	input  zmem_pkg::mem_data_t   push_data,

	input  logic                  pop,
	output logic                  empty,
	output zmem_pkg::mem_op_e     pop_op,
	output zmem_pkg::phys_addr_t  pop_addr,
	output zmem_pkg::mem_data_t   pop_data
);
	import zmem_pkg::*;

	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_bits = $clog2(depth + 1);
	localparam logic [ptr_bits-1:0] ptr_last = ptr_bits'(depth - 1);

	// entry storage
	mem_op_e    op_mem   [0:depth-1];
	phys_addr_t addr_mem [0:depth-1];
	mem_data_t  data_mem [0:depth-1];

	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [cnt_bits-1:0] count;

	logic do_pop;

	assign do_pop = pop && !empty;

	always_ff @(posedge fclk)
	begin
		if (push)
		begin
			op_mem[wr_ptr]   <= push_op;
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap by compare so any depth works
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !do_pop)
			begin
				count <= count + 1'b1;
			end
			else if (do_pop && !push)
			begin
				count <= count - 1'b1;
			end
		end
	end

	assign empty    = (count == '0);
	assign pop_op   = op_mem[rd_ptr];
	assign pop_addr = addr_mem[rd_ptr];
	assign pop_data = data_mem[rd_ptr];

endmodule

// ==== source/dram_seq.sv ====
`include "zmem_params.svh"

module dram_seq
(
	input  logic                  fclk,
	input  logic                  reset,

	// queue head
	input  logic                  empty,
	input  zmem_pkg::mem_op_e     pop_op,
	input  zmem_pkg::phys_addr_t  pop_addr,
	input  zmem_pkg::mem_data_t   pop_data,
	output logic                  pop,

	// back to the pager
	output logic                  credit_ret,

	// read return
	output logic                  rd_valid,
	output zmem_pkg::mem_data_t   rd_data
);
	import zmem_pkg::*;

	localparam int cyc_len   = `ZMEM_CYCLE_LEN;
	localparam int cnt_bits  = $clog2(cyc_len);
	localparam int mem_words = 2 ** $bits(phys_addr_t);
	localparam logic [cnt_bits-1:0] cnt_last = cnt_bits'(cyc_len - 1);

	seq_state_e state;
	logic [cnt_bits-1:0] cyc_cnt;

	// request in service
	mem_op_e    lat_op;
	phys_addr_t lat_addr;
	mem_data_t  lat_data;

	// on-chip stand-in for the dram, rom half on top
	mem_data_t mem_array [0:mem_words-1];

	initial
	begin
		for (int i = 0; i < mem_words; i++)
		begin
			mem_array[i] = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// cycle cadence
	////////////////////////////////////////////////////////////

	// cbeg, access, then cend until the counter wraps
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state   <= SEQ_IDLE;
			cyc_cnt <= '0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
				begin
					cyc_cnt <= '0;
					if (!empty)
					begin
						state <= SEQ_CBEG;
					end
				end
				SEQ_CBEG:
				begin
					cyc_cnt <= cyc_cnt + 1'b1;
					state   <= SEQ_ACCESS;
				end
				SEQ_ACCESS:
				begin
					cyc_cnt <= cyc_cnt + 1'b1;
					state   <= SEQ_CEND;
				end
				SEQ_CEND:
				begin
					if (cyc_cnt == cnt_last)
					begin
						cyc_cnt <= '0;
						// next cycle starts right away when work is waiting
						state   <= empty ? SEQ_IDLE : SEQ_CBEG;
					end
					else
					begin
						cyc_cnt <= cyc_cnt + 1'b1;
					end
				end
				default:
				begin
					state   <= SEQ_IDLE;
					cyc_cnt <= '0;
				end
			endcase
		end
	end

	// cbeg is only entered with a non-empty queue
	assign pop        = (state == SEQ_CBEG);
	assign credit_ret = (state == SEQ_CBEG);

	////////////////////////////////////////////////////////////
	// data path
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (state == SEQ_CBEG)
		begin
			lat_op   <= pop_op;
			lat_addr <= pop_addr;
			lat_data <= pop_data;
		end
		if (state == SEQ_ACCESS)
		begin
			if (lat_op == OP_WRITE)
			begin
				mem_array[lat_addr] <= lat_data;
			end
			else
			begin
				rd_data <= mem_array[lat_addr];
			end
		end
	end

	// read data is held from access until the end of the cycle
	assign rd_valid = (state == SEQ_CEND) && (cyc_cnt == cnt_last) && (lat_op == OP_READ);

endmodule

// ==== source/zmem_top.sv ====
`include "zmem_params.svh"

module zmem_top
(
	input  logic                  fclk,
	input  logic                  reset,

	input  logic                  req,
	input  zmem_pkg::mem_op_e     req_op,
	input  zmem_pkg::cpu_addr_t   req_addr,
	input  zmem_pkg::mem_data_t   req_wrdata,

	input  logic                  port_wr,
	input  zmem_pkg::cpu_addr_t   port_addr,
	input  zmem_pkg::mem_data_t   port_data,

	output logic                  busy,
	output logic                  rd_valid,
	output zmem_pkg::mem_data_t   rd_data
);
	import zmem_pkg::*;

	// pager to queue
	logic       push;
	mem_op_e    push_op;
	phys_addr_t push_addr;
	mem_data_t  push_data;

	// queue to sequencer
	logic       pop;
	logic       empty;
	mem_op_e    pop_op;
	phys_addr_t pop_addr;
	mem_data_t  pop_data;

	logic       credit_ret;

	zpager zpager0
	(
		.fclk      (fclk),
		.reset     (reset),
		.req       (req),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wrdata(req_wrdata),
		.port_wr   (port_wr),
		.port_addr (port_addr),
		.port_data (port_data),
		.credit_ret(credit_ret),
		.busy      (busy),
		.push      (push),
		.push_op   (push_op),
		.push_addr (push_addr),
		.push_data (push_data)
	);

	req_queue #(.depth(`ZMEM_QUEUE_DEPTH)) req_queue0
	(
		.fclk     (fclk),
		.reset    (reset),
		.push     (push),
		.push_op  (push_op),
		.push_addr(push_addr),
		.push_data(push_data),
		.pop      (pop),
		.empty    (empty),
		.pop_op   (pop_op),
		.pop_addr (pop_addr),
		.pop_data (pop_data)
	);

	dram_seq dram_seq0
	(
		.fclk      (fclk),
		.reset     (reset),
		.empty     (empty),
		.pop_op    (pop_op),
		.pop_addr  (pop_addr),
		.pop_data  (pop_data),
		.pop       (pop),
		.credit_ret(credit_ret),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

// ==== dv/tb_zmem.sv ====
`include "zmem_params.svh"

module tb_zmem;
	import zmem_pkg::*;

	localparam int seed           = 15341;
	localparam int random_items   = 4000;
	// requests and port writes of the directed part
	localparam int directed_items = 29;
	localparam int watchdog_limit =
		(directed_items + random_items + 20) * `ZMEM_CYCLE_LEN * 2 * 10;
	localparam int model_words    = 2 ** $bits(phys_addr_t);
	// full queue plus one in service, with margin
	localparam int drain_limit    = (`ZMEM_QUEUE_DEPTH + 2) * `ZMEM_CYCLE_LEN * 2;

	logic      fclk;
	logic      reset;
	logic      req;
	mem_op_e   req_op;
	cpu_addr_t req_addr;
	mem_data_t req_wrdata;
	logic      port_wr;
	cpu_addr_t port_addr;
	mem_data_t port_data;
	logic      busy;
	logic      rd_valid;
	mem_data_t rd_data;

	// reference model state
	mem_data_t  model_mem [0:model_words-1];
	page_t      model_page [0:3];
	logic [3:0] model_rom;
	logic       model_romrw;
	mem_data_t  exp_q [$];

	int   reads_issued;
	int   reads_returned;
	logic busy_seen;

	zmem_top dut0
	(
		.fclk      (fclk),
		.reset     (reset),
		.req       (req),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wrdata(req_wrdata),
		.port_wr   (port_wr),
		.port_addr (port_addr),
		.port_data (port_data),
		.busy      (busy),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

	initial
	begin
		fclk = 1'b0;
		forever #5 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic compare_data(input mem_data_t got);
		mem_data_t expected;
		if (exp_q.size() == 0)
		begin
			stop_with_failure("rd_valid pulsed while no read was outstanding");
		end
		else
		begin
			expected = exp_q.pop_front();
			if (got !== expected)
			begin
				stop_with_failure($sformatf("CHECK FAILED rd_data: expected 0x%h got 0x%h",
					expected, got));
			end
		end
	endtask

	task automatic compare_count(input int got);
		if (got !== reads_issued)
		begin
			stop_with_failure($sformatf("CHECK FAILED reads returned: expected 0x%h got 0x%h",
				reads_issued, got));
		end
	endtask

	// rom flag, page, then window offset
	function automatic phys_addr_t model_phys(input cpu_addr_t addr);
		logic [1:0] w;
		w = addr[15:14];
		return {model_rom[w], model_page[w], addr[`ZMEM_WIN_BITS-1:0]};
	endfunction

	////////////////////////////////////////////////////////////
	// drivers, all entered on a falling edge
	////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge fclk);
	endtask

	task automatic write_port(input cpu_addr_t addr, input mem_data_t data);
		logic [1:0] w;
		w         = addr[15:14];
		port_wr   = 1'b1;
		port_addr = addr;
		port_data = data;
		if (addr[7:0] == `ZMEM_PORT_PAGE)
		begin
			model_rom[w]  = ~data[7];
			model_page[w] = data[`ZMEM_PAGE_BITS-1:0];
		end
		else if (addr[7:0] == `ZMEM_PORT_CFG)
		begin
			model_romrw = data[0];
		end
		@(negedge fclk);
		port_wr = 1'b0;
	endtask

	task automatic issue_req(input mem_op_e op, input cpu_addr_t addr, input mem_data_t data);
		phys_addr_t pa;
		logic [1:0] w;
		req        = 1'b1;
		req_op     = op;
		req_addr   = addr;
		req_wrdata = data;
		// hold the request until a credit is free
		while (busy)
		begin
			@(negedge fclk);
		end
		w  = addr[15:14];
		pa = model_phys(addr);
		if (op == OP_READ)
		begin
			exp_q.push_back(model_mem[pa]);
			reads_issued++;
		end
		else if (!(model_rom[w] && !model_romrw))
		begin
			model_mem[pa] = data;
		end
		@(negedge fclk);
		req = 1'b0;
	endtask

	task automatic drain_reads();
		int waited;
		waited = 0;
		while ((reads_returned != reads_issued) && (waited < drain_limit))
		begin
			@(negedge fclk);
			waited++;
		end
		wait_cycles(2 * `ZMEM_CYCLE_LEN);
	endtask

	task automatic random_item();
		int        kind;
		cpu_addr_t addr;
		mem_data_t data;
		mem_op_e   op;
		kind = $urandom_range(0, 9);
		data = mem_data_t'($urandom_range(0, 255));
		if (kind == 0)
		begin
			addr = cpu_addr_t'($urandom_range(0, 65535));
			case ($urandom_range(0, 3))
				0, 1:
				begin
					addr[7:0] = `ZMEM_PORT_PAGE;
				end
				2:
				begin
					addr[7:0] = `ZMEM_PORT_CFG;
				end
				default:
				begin
				end
			endcase
			write_port(addr, data);
		end
		else
		begin
			// small offset range so reads hit earlier writes
			addr = {2'($urandom_range(0, 3)), 8'h00, 6'($urandom_range(0, 63))};
			op   = ($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE;
			issue_req(op, addr, data);
		end
		if ($urandom_range(0, 3) == 0)
		begin
			wait_cycles($urandom_range(1, 3));
		end
	endtask

	// read returns and busy, sampled mid cycle
	always @(negedge fclk)
	begin
		if (!reset)
		begin
			if (busy)
			begin
				busy_seen = 1'b1;
			end
			if (rd_valid)
			begin
				reads_returned++;
				compare_data(rd_data);
			end
		end
	end

	initial
	begin
		#(watchdog_limit);
		stop_with_failure("timeout: read responses stopped arriving before the test ended");
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		void'($urandom(seed));
		reset      = 1'b1;
		req        = 1'b0;
		req_op     = OP_READ;
		req_addr   = '0;
		req_wrdata = '0;
		port_wr    = 1'b0;
		port_addr  = '0;
		port_data  = '0;
		for (int i = 0; i < model_words; i++)
		begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < 4; i++)
		begin
			model_page[i] = page_t'(i);
		end
		model_rom      = 4'b0001;
		model_romrw    = 1'b0;
		reads_issued   = 0;
		reads_returned = 0;
		busy_seen      = 1'b0;

		wait_cycles(10);
		reset = 1'b0;
		@(negedge fclk);

		// reset map, ram windows then rom window 0
		for (int w = 1; w < 4; w++)
		begin
			issue_req(OP_WRITE, {2'(w), 14'(14'h0120 + w)}, mem_data_t'(8'h30 + w));
		end
		for (int w = 1; w < 4; w++)
		begin
			issue_req(OP_READ, {2'(w), 14'(14'h0120 + w)}, 8'h00);
		end
		issue_req(OP_READ, 16'h0000, 8'h00);
		issue_req(OP_READ, 16'h3FFF, 8'h00);

		// window 2 then window 3 onto ram page 5
		write_port({2'd2, 6'h00, `ZMEM_PORT_PAGE}, 8'h85);
		issue_req(OP_WRITE, 16'h8042, 8'h5A);
		write_port({2'd3, 6'h00, `ZMEM_PORT_PAGE}, 8'h85);
		issue_req(OP_READ, 16'hC042, 8'h00);

		// rom write dropped, then allowed by the config port
		issue_req(OP_WRITE, 16'h0010, 8'hA5);
		issue_req(OP_READ, 16'h0010, 8'h00);
		write_port({8'h00, `ZMEM_PORT_CFG}, 8'h01);
		issue_req(OP_WRITE, 16'h0010, 8'hA5);
		issue_req(OP_READ, 16'h0010, 8'h00);

		drain_reads();

		// burst deeper than queue plus one in service
		busy_seen = 1'b0;
		for (int i = 0; i < 12; i++)
		begin
			issue_req((i % 2 == 0) ? OP_WRITE : OP_READ,
				{2'd1, 14'(14'h0200 + i / 2)}, mem_data_t'(8'hC0 + i));
		end
		drain_reads();
		if (!busy_seen)
		begin
			stop_with_failure("busy never rose during the back-to-back request burst");
		end

		for (int i = 0; i < random_items; i++)
		begin
			random_item();
		end

		drain_reads();
		compare_count(reads_returned);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+source
source/zmem_pkg.sv
source/zpager.sv
source/req_queue.sv
source/dram_seq.sv
source/zmem_top.sv
dv/tb_zmem.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_zmem
RTL_TOP   ?= zmem_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# the log decides the result, the simulator status is ignored here
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
